// File: rtl/rom_loader_settings.svh
// ROM loader width settings
`ifndef ROM_LOADER_SETTINGS_SVH
`define ROM_LOADER_SETTINGS_SVH

// ################################################
// Download stream
// ################################################

// Byte address width of the download window
`define LD_ADDR_W 13

// Region number sits above this bit
`define LD_REGION_LSB 9

// ################################################
// Region memories
// ################################################

// 256 words per main region
`define MAIN_ADDR_W 8

// 512 bytes per sound region
`define SND_ADDR_W 9

`define MAIN_DATA_W 16
`define SND_DATA_W 8

// Active-low ROM select counts
`define MAIN_SEL_W 5
`define SND_SEL_W 3

`endif

// File: rtl/rom_loader_pkg.sv
// ROM loader shared types
`include "rom_loader_settings.svh"

package rom_loader_pkg;

	// ################################################
	// Region and command encodings
	// ################################################

	// Region number from download address bits 12 to 9
	// Numbers 10 and up all decode to REG_NONE
	typedef enum logic [3:0]
	{
		REG_ROM0  = 4'd0,
		REG_ROM1  = 4'd1,
		REG_ROM2  = 4'd2,
		REG_ROM5  = 4'd3,
		REG_ROM6  = 4'd4,
		REG_ROM7  = 4'd5,
		REG_SLAP  = 4'd6,
		REG_SROM0 = 4'd7,
		REG_SROM1 = 4'd8,
		REG_SROM2 = 4'd9,
		REG_NONE  = 4'd10
	} load_region_e;

	// Store write opcode
	typedef enum logic [1:0]
	{
		WK_NONE = 2'd0,
		WK_WORD = 2'd1,
		WK_BYTE = 2'd2
	} write_kind_e;

	// ################################################
	// Read bundles from store to mux
	// ################################################

	// One word per main region, indexed by region value
	typedef logic [6:0][`MAIN_DATA_W-1:0] main_bank_t;

	// One byte per sound region, SROM0 at index 0
	typedef logic [2:0][`SND_DATA_W-1:0] snd_bank_t;

endpackage

// File: rtl/load_write_if.sv
// Decoded load write bus
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

interface load_write_if;

	// Single-cycle command, WK_NONE when idle
	rom_loader_pkg::write_kind_e kind;

	// Target memory
	rom_loader_pkg::load_region_e region;

	// Word index in low 8 bits for words
	// Full byte index for sound bytes
	logic [`SND_ADDR_W-1:0] offset;

	// Sound writes use the low byte only
	logic [`MAIN_DATA_W-1:0] data;

	// Decoder side
	modport source
	(
		output kind,
		output region,
		output offset,
		output data
	);

	// Memory side
	modport sink
	(
		input kind,
		input region,
		input offset,
		input data
	);

endinterface

// File: rtl/download_decoder.sv
// Download stream decoder
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module download_decoder
(
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  logic [15:0]            ioctl_index,
	input  logic [`LD_ADDR_W-1:0]  ioctl_addr,
	input  logic [`SND_DATA_W-1:0] ioctl_dout,
	load_write_if.source           wr_bus
);

	logic                         wr_accept;
	logic [3:0]                   region_num;
	rom_loader_pkg::load_region_e region_dec;
	logic                         is_main;
	logic                         is_snd;
	rom_loader_pkg::write_kind_e  kind_nxt;
	logic [`SND_ADDR_W-1:0]       offset_nxt;
	logic [`MAIN_DATA_W-1:0]      data_nxt;
	logic [`SND_DATA_W-1:0]       last_byte;

	// ################################################
	// Stream filter and region decode
	// ################################################

	// Index 0 carries the program and sound ROMs
	assign wr_accept = ioctl_wr && ioctl_download && (ioctl_index == 16'd0);

	assign region_num = ioctl_addr[`LD_ADDR_W-1:`LD_REGION_LSB];

	// Fold unmapped numbers onto REG_NONE
	always_comb
	begin
		if (region_num > 4'(rom_loader_pkg::REG_SROM2))
			region_dec = rom_loader_pkg::REG_NONE;
		else
			region_dec = rom_loader_pkg::load_region_e'(region_num);
	end

	assign is_main = (region_dec <= rom_loader_pkg::REG_SLAP);
	assign is_snd  = (region_dec >= rom_loader_pkg::REG_SROM0) &&
		(region_dec <= rom_loader_pkg::REG_SROM2);

	// Main words complete on the odd byte
	always_comb
	begin
		kind_nxt = rom_loader_pkg::WK_NONE;
		if (wr_accept && is_main && ioctl_addr[0])
			kind_nxt = rom_loader_pkg::WK_WORD;
		else if (wr_accept && is_snd)
			kind_nxt = rom_loader_pkg::WK_BYTE;
	end

	// Even byte lands in the high half
	assign data_nxt = is_main ? {last_byte, ioctl_dout} :
		{{(`MAIN_DATA_W-`SND_DATA_W){1'b0}}, ioctl_dout};

	// Word index drops the byte lane bit
	assign offset_nxt = is_main ? `SND_ADDR_W'(ioctl_addr[`LD_REGION_LSB-1:1]) :
		ioctl_addr[`LD_REGION_LSB-1:0];

	// ################################################
	// Command register
	// ################################################

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			wr_bus.kind <= rom_loader_pkg::WK_NONE;
		else
			wr_bus.kind <= kind_nxt;
	end

	// Payload follows the kind, only meaningful when kind is live
	always_ff @(posedge clk_sys)
	begin
		wr_bus.region <= region_dec;
		wr_bus.offset <= offset_nxt;
		wr_bus.data   <= data_nxt;
		// Previous byte for packing
		if (wr_accept)
			last_byte <= ioctl_dout;
	end

endmodule

// File: rtl/rom_bank_store.sv
// Region ROM store
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module rom_bank_store
(
	input  logic                       clk_sys,
	load_write_if.sink                 wr_bus,
	input  logic [`MAIN_ADDR_W-1:0]    cpu_word_addr,
	input  logic [`SND_ADDR_W-1:0]     snd_addr,
	output rom_loader_pkg::main_bank_t main_q,
	output rom_loader_pkg::snd_bank_t  snd_q
);

	// Memory counts follow the bundle shapes
	localparam int MAIN_BANKS = $size(rom_loader_pkg::main_bank_t);
	localparam int SND_BANKS  = $size(rom_loader_pkg::snd_bank_t);

	logic wr_word;
	logic wr_byte;

	// Command decode shared by all memories
	assign wr_word = (wr_bus.kind == rom_loader_pkg::WK_WORD);
	assign wr_byte = (wr_bus.kind == rom_loader_pkg::WK_BYTE);

	// ################################################
	// Main program memories
	// ################################################

	// Region value doubles as the bank index
	for (genvar g = 0; g < MAIN_BANKS; g++)
	begin : g_main
		logic [`MAIN_DATA_W-1:0] mem [1 << `MAIN_ADDR_W];
		logic                    hit;

		assign hit = wr_word && (wr_bus.region == rom_loader_pkg::load_region_e'(g));

		always_ff @(posedge clk_sys)
		begin
			if (hit)
				mem[wr_bus.offset[`MAIN_ADDR_W-1:0]] <= wr_bus.data;
			// Read-before-write on a same-cycle hit
			main_q[g] <= mem[cpu_word_addr];
		end
	end

	// ################################################
	// Sound memories
	// ################################################

	// SROM0 is the first sound region value
	for (genvar g = 0; g < SND_BANKS; g++)
	begin : g_snd
		logic [`SND_DATA_W-1:0] mem [1 << `SND_ADDR_W];
		logic                   hit;

		assign hit = wr_byte &&
			(wr_bus.region == rom_loader_pkg::load_region_e'(rom_loader_pkg::REG_SROM0 + g));

		always_ff @(posedge clk_sys)
		begin
			if (hit)
				mem[wr_bus.offset] <= wr_bus.data[`SND_DATA_W-1:0];
			// Sound CPU address reads all three
			snd_q[g] <= mem[snd_addr];
		end
	end

endmodule

// File: rtl/program_read_mux.sv
// Program and sound read select
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module program_read_mux
(
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic [`MAIN_SEL_W-1:0]     cpu_rom_sel_n,
	input  logic                       cpu_ma18_n,
	input  logic [`SND_SEL_W-1:0]      snd_rom_sel_n,
	input  rom_loader_pkg::main_bank_t main_q,
	input  rom_loader_pkg::snd_bank_t  snd_q,
	output logic [`MAIN_DATA_W-1:0]    cpu_data,
	output logic [`SND_DATA_W-1:0]     snd_data
);

	logic [`MAIN_SEL_W-1:0]  cpu_sel_q;
	logic                    ma18_q;
	logic [`SND_SEL_W-1:0]   snd_sel_q;
	logic [`MAIN_DATA_W-1:0] cpu_pick;
	logic [`SND_DATA_W-1:0]  snd_pick;

	// ################################################
	// Select delay
	// ################################################

	// Lines the selects up with the registered bank reads
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cpu_sel_q <= '1;
			ma18_q    <= 1'b1;
			snd_sel_q <= '1;
		end
		else
		begin
			cpu_sel_q <= cpu_rom_sel_n;
			ma18_q    <= cpu_ma18_n;
			snd_sel_q <= snd_rom_sel_n;
		end
	end

	// ################################################
	// Priority select
	// ################################################

	// High bank first, then low bank, then slapstic
	// ROM3 select reads the ROM7 memory in both banks
	always_comb
	begin
		if (!cpu_sel_q[0] && ma18_q)
			cpu_pick = main_q[rom_loader_pkg::REG_ROM0];
		else if (!cpu_sel_q[1] && ma18_q)
			cpu_pick = main_q[rom_loader_pkg::REG_ROM1];
		else if (!cpu_sel_q[2] && ma18_q)
			cpu_pick = main_q[rom_loader_pkg::REG_ROM2];
		else if (!cpu_sel_q[3] && ma18_q)
			cpu_pick = main_q[rom_loader_pkg::REG_ROM7];
		else if (!cpu_sel_q[1] && !ma18_q)
			cpu_pick = main_q[rom_loader_pkg::REG_ROM5];
		else if (!cpu_sel_q[2] && !ma18_q)
			cpu_pick = main_q[rom_loader_pkg::REG_ROM6];
		else if (!cpu_sel_q[3] && !ma18_q)
			cpu_pick = main_q[rom_loader_pkg::REG_ROM7];
		else if (!cpu_sel_q[4])
			cpu_pick = main_q[rom_loader_pkg::REG_SLAP];
		else
			cpu_pick = '0;
	end

	// Lowest select wins
	always_comb
	begin
		if (!snd_sel_q[0])
			snd_pick = snd_q[0];
		else if (!snd_sel_q[1])
			snd_pick = snd_q[1];
		else if (!snd_sel_q[2])
			snd_pick = snd_q[2];
		else
			snd_pick = '0;
	end

	// Output register, second read edge
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cpu_data <= '0;
			snd_data <= '0;
		end
		else
		begin
			cpu_data <= cpu_pick;
			snd_data <= snd_pick;
		end
	end

endmodule

// File: rtl/rom_loader_top.sv
// ROM loader top level
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module rom_loader_top
(
	input  logic                    clk_sys,
	input  logic                    arst_n,

	// Download stream
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [15:0]             ioctl_index,
	input  logic [`LD_ADDR_W-1:0]   ioctl_addr,
	input  logic [`SND_DATA_W-1:0]  ioctl_dout,

	// Main CPU ROM side
	input  logic [`MAIN_SEL_W-1:0]  cpu_rom_sel_n,
	input  logic                    cpu_ma18_n,
	input  logic [`MAIN_ADDR_W-1:0] cpu_word_addr,

	// Sound CPU ROM side
	input  logic [`SND_SEL_W-1:0]   snd_rom_sel_n,
	input  logic [`SND_ADDR_W-1:0]  snd_addr,

	output logic [`MAIN_DATA_W-1:0] cpu_data,
	output logic [`SND_DATA_W-1:0]  snd_data
);

	rom_loader_pkg::main_bank_t main_q;
	rom_loader_pkg::snd_bank_t  snd_q;

	// Decoded writes into the store
	load_write_if wr_bus ();

	// ################################################
	// Stage 1, stream to write commands
	// ################################################

	download_decoder u_decoder
	(
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.wr_bus         (wr_bus.source)
	);

	// Stage 2, region memories
	rom_bank_store u_store
	(
		.clk_sys       (clk_sys),
		.wr_bus        (wr_bus.sink),
		.cpu_word_addr (cpu_word_addr),
		.snd_addr      (snd_addr),
		.main_q        (main_q),
		.snd_q         (snd_q)
	);

	// Stage 3, select and register read data
	program_read_mux u_read
	(
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.cpu_rom_sel_n (cpu_rom_sel_n),
		.cpu_ma18_n    (cpu_ma18_n),
		.snd_rom_sel_n (snd_rom_sel_n),
		.main_q        (main_q),
		.snd_q         (snd_q),
		.cpu_data      (cpu_data),
		.snd_data      (snd_data)
	);

endmodule

// File: dv/rom_loader_properties.sv
// ROM loader bound properties
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module rom_loader_properties
(
	input logic                         clk_sys,
	input logic                         arst_n,
	input logic                         ioctl_download,
	input logic                         ioctl_wr,
	input logic [15:0]                  ioctl_index,
	input rom_loader_pkg::write_kind_e  wr_kind,
	input rom_loader_pkg::load_region_e wr_region,
	input logic [`MAIN_DATA_W-1:0]      cpu_data,
	input logic [`SND_DATA_W-1:0]       snd_data
);

	logic wr_accept;
	logic snd_region;

	// Same filter as the download stream rules
	assign wr_accept  = ioctl_wr && ioctl_download && (ioctl_index == 16'd0);
	assign snd_region = (wr_region >= rom_loader_pkg::REG_SROM0) &&
		(wr_region <= rom_loader_pkg::REG_SROM2);

	// Live command needs an accepted byte one edge earlier
	cmd_follows_accept: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(wr_kind != rom_loader_pkg::WK_NONE) |-> $past(wr_accept))
		else $error("write command without an accepted download byte");

	// Sound memories only take bytes
	no_word_to_sound: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(wr_kind == rom_loader_pkg::WK_WORD) |-> !snd_region)
		else $error("word write aimed at a sound region");

	// Outputs still clear one cycle out of reset
	zero_after_reset: assert property (@(posedge clk_sys)
		$rose(arst_n) |=> (cpu_data == '0) && (snd_data == '0))
		else $error("read data not zero after reset release");

endmodule

// File: dv/rom_loader_tb.sv
// ROM loader testbench
`timescale 1ns/1ps
`include "rom_loader_settings.svh"

module rom_loader_tb;

	localparam int N_LOAD   = 24;
	localparam int N_READ   = 22;
	localparam int WD_LIMIT = 20 * (N_LOAD + N_READ) + 100;

	logic                    clk_sys;
	logic                    arst_n;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [15:0]             ioctl_index;
	logic [`LD_ADDR_W-1:0]   ioctl_addr;
	logic [`SND_DATA_W-1:0]  ioctl_dout;
	logic [`MAIN_SEL_W-1:0]  cpu_rom_sel_n;
	logic                    cpu_ma18_n;
	logic [`MAIN_ADDR_W-1:0] cpu_word_addr;
	logic [`SND_SEL_W-1:0]   snd_rom_sel_n;
	logic [`SND_ADDR_W-1:0]  snd_addr;
	logic [`MAIN_DATA_W-1:0] cpu_data;
	logic [`SND_DATA_W-1:0]  snd_data;

	// Load table rows
	// Mode 0 is accepted, mode 1 has download low and mode 2 a nonzero index
	string       ld_name   [N_LOAD];
	int          ld_region [N_LOAD];
	int          ld_offset [N_LOAD];
	int          ld_mode   [N_LOAD];
	logic [15:0] ld_value  [N_LOAD];
	int          n_ld;

	// Read table rows
	// Expected value holds the cpu word above the sound byte
	string                   rd_name     [N_READ];
	logic [`MAIN_SEL_W-1:0]  rd_cpu_sel  [N_READ];
	logic                    rd_ma18     [N_READ];
	logic [`MAIN_ADDR_W-1:0] rd_cpu_addr [N_READ];
	logic [`SND_SEL_W-1:0]   rd_snd_sel  [N_READ];
	logic [`SND_ADDR_W-1:0]  rd_snd_addr [N_READ];
	logic [23:0]             rd_expect   [N_READ];
	int                      n_rd;

	// Table row in progress
	string                   step_name;

	// Reference copy of every loaded location
	logic [15:0] main_model [7][1 << `MAIN_ADDR_W];
	logic [7:0]  snd_model  [3][1 << `SND_ADDR_W];
	logic [31:0] lcg_state;

	rom_loader_top u_dut (.*);

	bind rom_loader_top rom_loader_properties u_props
	(
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.wr_kind        (wr_bus.kind),
		.wr_region      (wr_bus.region),
		.cpu_data       (cpu_data),
		.snd_data       (snd_data)
	);

	always #5 clk_sys = ~clk_sys;

	// ################################################
	// Table helpers and reference rules
	// ################################################

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic void add_load(input string name, input int region, input int offset,
		input int mode);
		ld_name[n_ld]   = name;
		ld_region[n_ld] = region;
		ld_offset[n_ld] = offset;
		ld_mode[n_ld]   = mode;
		ld_value[n_ld]  = next_rand();
		n_ld++;
	endfunction

	function automatic void add_read(input string name, input logic [4:0] cpu_sel,
		input logic ma18, input logic [7:0] cpu_addr, input logic [2:0] snd_sel,
		input logic [8:0] s_addr);
		rd_name[n_rd]     = name;
		rd_cpu_sel[n_rd]  = cpu_sel;
		rd_ma18[n_rd]     = ma18;
		rd_cpu_addr[n_rd] = cpu_addr;
		rd_snd_sel[n_rd]  = snd_sel;
		rd_snd_addr[n_rd] = s_addr;
		n_rd++;
	endfunction

	// First low select wins within the group picked by MA18n
	// SLAP comes after both groups
	function automatic logic [15:0] expect_cpu(input logic [4:0] sel, input logic ma18,
		input logic [7:0] addr);
		int hi_map [4];
		int lo_map [4];
		int bank;
		hi_map = '{int'(rom_loader_pkg::REG_ROM0), int'(rom_loader_pkg::REG_ROM1),
			int'(rom_loader_pkg::REG_ROM2), int'(rom_loader_pkg::REG_ROM7)};
		// Select 0 has no low-bank ROM
		lo_map = '{-1, int'(rom_loader_pkg::REG_ROM5), int'(rom_loader_pkg::REG_ROM6),
			int'(rom_loader_pkg::REG_ROM7)};
		bank = -1;
		for (int k = 0; k < 4; k++)
		begin
			if (bank < 0 && !sel[k])
				bank = ma18 ? hi_map[k] : lo_map[k];
		end
		if (bank < 0 && !sel[4])
			bank = int'(rom_loader_pkg::REG_SLAP);
		return (bank < 0) ? 16'h0000 : main_model[bank][addr];
	endfunction

	function automatic logic [7:0] expect_snd(input logic [2:0] sel, input logic [8:0] addr);
		for (int k = 0; k < 3; k++)
		begin
			if (!sel[k])
				return snd_model[k][addr];
		end
		return 8'h00;
	endfunction

	// ################################################
	// Bus drivers and checks
	// ################################################

	// One strobe cycle per byte and an idle cycle after it
	task automatic send_byte(input logic [`LD_ADDR_W-1:0] addr, input logic [7:0] data,
		input logic dl, input logic [15:0] idx);
		@(posedge clk_sys);
		ioctl_wr       <= 1'b1;
		ioctl_download <= dl;
		ioctl_index    <= idx;
		ioctl_addr     <= addr;
		ioctl_dout     <= data;
		@(posedge clk_sys);
		ioctl_wr       <= 1'b0;
		ioctl_download <= 1'b1;
		ioctl_index    <= 16'd0;
	endtask

	task automatic apply_load(input int i);
		logic [3:0]  region;
		logic        dl;
		logic [15:0] idx;
		logic        accepted;
		step_name = ld_name[i];
		region    = 4'(ld_region[i]);
		dl        = (ld_mode[i] != 1);
		idx       = (ld_mode[i] == 2) ? 16'd1 : 16'd0;
		accepted  = (ld_mode[i] == 0);
		if (ld_region[i] >= int'(rom_loader_pkg::REG_SROM0) && ld_region[i] <= 9)
		begin
			send_byte({region, 9'(ld_offset[i])}, ld_value[i][7:0], dl, idx);
			if (accepted)
				snd_model[ld_region[i] - 7][ld_offset[i]] = ld_value[i][7:0];
		end
		else
		begin
			// Even byte is the high half of the word
			send_byte({region, 8'(ld_offset[i]), 1'b0}, ld_value[i][15:8], dl, idx);
			send_byte({region, 8'(ld_offset[i]), 1'b1}, ld_value[i][7:0], dl, idx);
			// Unmapped numbers 10 and up store nothing
			if (accepted && ld_region[i] < 7)
				main_model[ld_region[i]][ld_offset[i]] = ld_value[i];
		end
	endtask

	task automatic check_read(input int i);
		assert ({cpu_data, snd_data} === rd_expect[i])
		else
		begin
			$display("mismatch %s expected %h actual %h", rd_name[i], rd_expect[i],
				{cpu_data, snd_data});
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic build_tables();
		// Two locations in each of the ten regions
		for (int r = 0; r < 10; r++)
		begin
			add_load($sformatf("load region %0d a", r), r, (r < 7) ? 'h05 : 'h007, 0);
			add_load($sformatf("load region %0d b", r), r, (r < 7) ? 'hA2 : 'h1F3, 0);
		end
		// Writes that must leave loaded data alone
		add_load("reject download low rom0", int'(rom_loader_pkg::REG_ROM0), 'h05, 1);
		add_load("reject index srom1", int'(rom_loader_pkg::REG_SROM1), 'h007, 2);
		add_load("reject index rom7", int'(rom_loader_pkg::REG_ROM7), 'hA2, 2);
		add_load("reject unmapped region", 11, 'h05, 0);

		add_read("hi rom0", 5'b11110, 1'b1, 8'h05, 3'b110, 9'h007);
		add_read("hi rom1", 5'b11101, 1'b1, 8'hA2, 3'b101, 9'h1F3);
		add_read("hi rom2", 5'b11011, 1'b1, 8'h05, 3'b011, 9'h007);
		add_read("hi rom3 alias", 5'b10111, 1'b1, 8'hA2, 3'b111, 9'h007);
		add_read("lo rom5", 5'b11101, 1'b0, 8'h05, 3'b110, 9'h1F3);
		add_read("lo rom6", 5'b11011, 1'b0, 8'hA2, 3'b101, 9'h007);
		add_read("lo rom7", 5'b10111, 1'b0, 8'h05, 3'b011, 9'h1F3);
		add_read("hi rom7 same", 5'b10111, 1'b1, 8'h05, 3'b111, 9'h1F3);
		add_read("slap", 5'b01111, 1'b1, 8'hA2, 3'b111, 9'h007);
		add_read("multi hi", 5'b11000, 1'b1, 8'h05, 3'b000, 9'h007);
		add_read("multi lo", 5'b11000, 1'b0, 8'hA2, 3'b100, 9'h1F3);
		add_read("sel0 lo to slap", 5'b01110, 1'b0, 8'h05, 3'b001, 9'h007);
		add_read("sel0 lo to zero", 5'b11110, 1'b0, 8'hA2, 3'b111, 9'h1F3);
		add_read("all high", 5'b11111, 1'b1, 8'h05, 3'b111, 9'h007);
		add_read("kept rom0", 5'b11110, 1'b1, 8'h05, 3'b101, 9'h007);
		add_read("kept rom7", 5'b10111, 1'b0, 8'hA2, 3'b111, 9'h007);
		add_read("pipe a", 5'b11110, 1'b1, 8'hA2, 3'b011, 9'h1F3);
		add_read("pipe b", 5'b11011, 1'b0, 8'h05, 3'b110, 9'h007);
		add_read("pipe c", 5'b01111, 1'b0, 8'hA2, 3'b101, 9'h1F3);
		add_read("pipe d", 5'b11101, 1'b1, 8'h05, 3'b011, 9'h007);
		add_read("pipe e", 5'b10111, 1'b1, 8'hA2, 3'b110, 9'h1F3);
		add_read("pipe f", 5'b11111, 1'b0, 8'h05, 3'b101, 9'h007);
	endtask

	// ################################################
	// Main sequence and watchdog
	// ################################################

	initial
	begin
		clk_sys        = 1'b0;
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 16'd0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		cpu_rom_sel_n  = '1;
		cpu_ma18_n     = 1'b1;
		cpu_word_addr  = '0;
		snd_rom_sel_n  = '1;
		snd_addr       = '0;
		lcg_state      = 32'd24690;
		n_ld           = 0;
		n_rd           = 0;
		step_name      = "reset";
		build_tables();

		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		for (int i = 0; i < n_ld; i++)
			apply_load(i);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);

		// One read per cycle with its check two edges later
		for (int i = 0; i < n_rd + 2; i++)
		begin
			@(posedge clk_sys);
			if (i < n_rd)
			begin
				step_name = rd_name[i];
				cpu_rom_sel_n <= rd_cpu_sel[i];
				cpu_ma18_n    <= rd_ma18[i];
				cpu_word_addr <= rd_cpu_addr[i];
				snd_rom_sel_n <= rd_snd_sel[i];
				snd_addr      <= rd_snd_addr[i];
				rd_expect[i] = {expect_cpu(rd_cpu_sel[i], rd_ma18[i], rd_cpu_addr[i]),
					expect_snd(rd_snd_sel[i], rd_snd_addr[i])};
			end
			else
			begin
				cpu_rom_sel_n <= '1;
				snd_rom_sel_n <= '1;
			end
			@(negedge clk_sys);
			if (i >= 2)
				check_read(i - 2);
		end

		$display("TESTS PASSED");
		$finish;
	end

	initial
	begin
		repeat (WD_LIMIT) @(posedge clk_sys);
		$display("timeout, the run did not finish within %0d cycles, stuck at %s",
			WD_LIMIT, step_name);
		$display("TESTS FAILED");
		$fatal(1);
	end

endmodule

// File: all.f
+incdir+rtl
rtl/rom_loader_pkg.sv
rtl/load_write_if.sv
rtl/download_decoder.sv
rtl/rom_bank_store.sv
rtl/program_read_mux.sv
rtl/rom_loader_top.sv
dv/rom_loader_properties.sv
dv/rom_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ROM loader testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module rom_loader_tb \
	-Mdir obj_dir > build.log 2>&1 &&
./obj_dir/Vrom_loader_tb > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

# Pass only when the testbench printed its pass line
grep -q "^TESTS PASSED$" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
